/* chess_ctrl.f */
logic/axi_lite_pkg.sv
logic/chess_ctrl_pkg.sv
logic/ctrl_axi_write.sv
logic/position_regs.sv
logic/ctrl_read_mux.sv
logic/ctrl_axi_read.sv
logic/chess_ctrl.sv
dv/chess_ctrl_props.sv
dv/chess_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the chess_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module chess_ctrl_tb \
   -f chess_ctrl.f -o chess_ctrl_sim
if [ $? -ne 0 ]; then
   echo "Compile failed"
   exit 1
fi

./obj_dir/chess_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
exit 0

/* dv/chess_ctrl_tb.sv */
`timescale 1ns/1ps

module chess_ctrl_tb;

   import axi_lite_pkg::*;
   import chess_ctrl_pkg::*;

   logic                   clk;
   logic                   arst_n;
   logic [addr_w-1:0]      awaddr, araddr;
   logic [prot_w-1:0]      awprot, arprot;
   logic [data_w-1:0]      wdata, rdata;
   logic [strb_w-1:0]      wstrb;
   logic                   awvalid, wvalid, bready, arvalid, rready;
   logic                   awready, wready, bvalid, arready, rvalid;
   axi_resp_e              bresp, rresp;
   gen_status_t            gen_status;
   move_result_t           move_result;
   ctrl_t                  ctrl, model_ctrl;
   logic [pos_idx_w-1:0]   move_index, model_idx;
   position_t              position, model_pos;
   logic [word_addr_w-1:0] addr_list[$];
   logic [word_addr_w-1:0] wa;
   reg_addr_e              e;
   integer                 seed;

   chess_ctrl DUT (.*);

   bind chess_ctrl chess_ctrl_props u_props
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .awready (awready),
      .bvalid  (bvalid),
      .bready  (bready),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_rdata(input string name, input logic [data_w-1:0] got, exp);
      if (got !== exp)
         abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_resp(input string name, input axi_resp_e got, exp);
      if (got !== exp)
         abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_outputs(input ctrl_t got_c, exp_c,
                                input logic [pos_idx_w-1:0] got_i, exp_i,
                                input position_t got_p, exp_p);
      if (got_c !== exp_c)
         abort_run($sformatf("ERR ctrl got %h expected %h", got_c, exp_c));
      if (got_i !== exp_i)
         abort_run($sformatf("ERR move_index got %h expected %h", got_i, exp_i));
      if (got_p !== exp_p)
         abort_run($sformatf("ERR position got %h expected %h", got_p, exp_p));
   endtask

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic level(input string what);
      case (what)
         "awready": return awready && wready;
         "bvalid":  return bvalid;
         "arready": return arready;
         default:   return rvalid;
      endcase
   endfunction

   task automatic wait_high(input string what);
      int n;
      n = 0;
      while (!level(what))
      begin
         @(posedge clk);
         #1;
         n++;
         if (n >= 100)
            abort_run($sformatf("Timeout after 100 cycles waiting for %s", what));
      end
   endtask

   task automatic model_write(input logic [word_addr_w-1:0] a, input logic [data_w-1:0] d);
      int r;
      r = int'(a);
      case (a)
         CTRL:       model_ctrl = '{new_board_valid: d[0], clear_moves: d[1],
                                    use_random_bit: d[30], soft_reset: d[31]};
         MOVE_INDEX: model_idx = d[pos_idx_w-1:0];
         SIDE:
         begin
            model_pos.white_to_move  = d[8];
            model_pos.castle_mask    = d[7:4];
            model_pos.en_passant_col = d[3:0];
         end
         HALF_MOVE:  model_pos.half_move = d[half_move_w-1:0];
         default:
            if (r >= 8 && r <= 15)
               model_pos.board[(r-8)*rank_w +: rank_w] = d;  // Others are read-only
      endcase
   endtask

   function automatic logic [data_w-1:0] expected_read(input logic [word_addr_w-1:0] a);
      logic [data_w-1:0] w;
      int                r;
      w = '0;
      r = int'(a);
      if (r >= 8 && r <= 15)
         w = model_pos.board[(r-8)*rank_w +: rank_w];
      else if (r >= 172 && r <= 179)
         w = move_result.board[(r-172)*rank_w +: rank_w];
      else
         case (a)
            CTRL:       w = {model_ctrl.soft_reset, model_ctrl.use_random_bit, 19'b0,
                             gen_status.check, 2'b0, gen_status.idle, 1'b0, gen_status.mate,
                             gen_status.stalemate, gen_status.move_ready,
                             gen_status.moves_ready, model_ctrl.clear_moves,
                             model_ctrl.new_board_valid};
            MOVE_INDEX: w = data_w'(model_idx);
            SIDE:       w = data_w'({model_pos.white_to_move, model_pos.castle_mask,
                                     model_pos.en_passant_col});
            HALF_MOVE:  w = data_w'(model_pos.half_move);
            MOVE_EVAL:  w = data_w'($signed(move_result.eval));
            MOVE_COUNT: w = data_w'(move_result.move_count);
            MOVE_UCI:
            begin
               w[19:16] = move_result.uci[15:12];
               for (int f = 0; f < 4; f++)
                  w[f*4 +: 3] = move_result.uci[f*3 +: 3];   // Gap bit above each field
            end
            default:    w = '0;
         endcase
      return w;
   endfunction

   task automatic axi_write(input logic [word_addr_w-1:0] a, input logic [data_w-1:0] d);
      awaddr  = addr_w'({a, 2'($random(seed))});
      awprot  = prot_w'($random(seed));
      wstrb   = strb_w'($random(seed));
      wdata   = d;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      wait_high("awready");
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      wait_high("bvalid");
      if (awready || wready)
         abort_run("Write channel ready while a write response is pending");
      repeat (rand_below(4))
      begin
         @(posedge clk);
         #1;
         if (!bvalid)
            abort_run("bvalid dropped before bready was given");
         if (awready || wready)
            abort_run("Write channel ready while a write response is pending");
      end
      check_resp("bresp", bresp, OKAY);
      bready = 1'b1;
      @(posedge clk);
      #1;
      bready = 1'b0;
      model_write(a, d);
      check_outputs(ctrl, model_ctrl, move_index, model_idx, position, model_pos);
   endtask

   task automatic axi_read(input logic [word_addr_w-1:0] a, input logic [data_w-1:0] exp);
      logic [data_w-1:0] first;
      araddr  = addr_w'({a, 2'($random(seed))});
      arprot  = prot_w'($random(seed));
      arvalid = 1'b1;
      wait_high("arready");
      @(posedge clk);
      #1;
      arvalid = 1'b0;
      wait_high("rvalid");
      if (arready)
         abort_run("arready high while a read response is pending");
      first = rdata;
      repeat (rand_below(4))
      begin
         @(posedge clk);
         #1;
         if (!rvalid)
            abort_run("rvalid dropped before rready was given");
         if (arready)
            abort_run("arready high while a read response is pending");
         check_rdata("rdata (held)", rdata, first);
      end
      check_rdata($sformatf("rdata[addr %0d]", a), rdata, exp);
      check_resp("rresp", rresp, OKAY);
      rready = 1'b1;
      @(posedge clk);
      #1;
      rready = 1'b0;
   endtask

   task automatic randomize_generator();
      logic [319:0] bits;
      for (int i = 0; i < 10; i++)
         bits[i*32 +: 32] = $random(seed);
      gen_status  = gen_status_t'(6'($random(seed)));
      move_result = bits[$bits(move_result_t)-1:0];
   endtask

   initial
   begin
      seed        = 32'h426b6691;
      arst_n      = 1'b0;
      awaddr      = '0;
      araddr      = '0;
      awprot      = '0;
      arprot      = '0;
      wdata       = '0;
      wstrb       = '0;
      awvalid     = 1'b0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      gen_status  = '0;
      move_result = '0;
      model_ctrl  = '0;
      model_idx   = '0;
      model_pos   = '0;
      e = e.first();
      for (int i = 0; i < e.num(); i++)
      begin
         addr_list.push_back(e);
         e = e.next();
      end
      repeat (5) @(posedge clk);
      #1;
      arst_n = 1'b1;
      check_outputs(ctrl, model_ctrl, move_index, model_idx, position, model_pos);
      randomize_generator();
      axi_read(CTRL, expected_read(CTRL));            // Status bits only
      repeat (400)
      begin
         randomize_generator();
         if (rand_below(4) == 0)
            wa = word_addr_w'($random(seed));         // Mostly unmapped
         else
            wa = addr_list[rand_below(addr_list.size())];
         if (rand_below(2) == 0)
            axi_write(wa, $random(seed));
         else
            axi_read(wa, expected_read(wa));
      end
      if (DUT.u_props.b_fails + DUT.u_props.r_fails + DUT.u_props.aw_fails != 0)
         abort_run("AXI handshake assertion failed during the run");
      else
      begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

/* dv/chess_ctrl_props.sv */
`timescale 1ns/1ps

module chess_ctrl_props
(
   input logic                            clk,
   input logic                            arst_n,
   input logic                            awready,
   input logic                            bvalid,
   input logic                            bready,
   input logic                            rvalid,
   input logic                            rready,
   input logic [axi_lite_pkg::data_w-1:0] rdata
);

   int unsigned b_fails  = 0;
   int unsigned r_fails  = 0;
   int unsigned aw_fails = 0;

   // B response waits for the master
   b_hold: assert property (@(posedge clk) disable iff (!arst_n)
                            bvalid && !bready |=> bvalid)
   else
   begin
      $error("bvalid dropped before bready");
      b_fails++;
   end

   r_hold: assert property (@(posedge clk) disable iff (!arst_n)
                            rvalid && !rready |=> rvalid && $stable(rdata))
   else
   begin
      $error("rvalid or rdata changed before rready");
      r_fails++;
   end

   // No new write while a response is pending
   aw_block: assert property (@(posedge clk) disable iff (!arst_n)
                              bvalid |-> !awready)
   else
   begin
      $error("awready high while bvalid pending");
      aw_fails++;
   end

endmodule

/* logic/chess_ctrl.sv */
`timescale 1ns/1ps

module chess_ctrl
(
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic [axi_lite_pkg::addr_w-1:0]      awaddr,
   input  logic [axi_lite_pkg::prot_w-1:0]      awprot,
   input  logic                                 awvalid,
   input  logic [axi_lite_pkg::data_w-1:0]      wdata,
   input  logic [axi_lite_pkg::strb_w-1:0]      wstrb,
   input  logic                                 wvalid,
   input  logic                                 bready,
   input  logic [axi_lite_pkg::addr_w-1:0]      araddr,
   input  logic [axi_lite_pkg::prot_w-1:0]      arprot,
   input  logic                                 arvalid,
   input  logic                                 rready,
   output logic                                 awready,
   output logic                                 wready,
   output logic                                 bvalid,
   output axi_lite_pkg::axi_resp_e              bresp,
   output logic                                 arready,
   output logic                                 rvalid,
   output logic [axi_lite_pkg::data_w-1:0]      rdata,
   output axi_lite_pkg::axi_resp_e              rresp,
   input  chess_ctrl_pkg::gen_status_t          gen_status,
   input  chess_ctrl_pkg::move_result_t         move_result,
   output chess_ctrl_pkg::ctrl_t                ctrl,
   output logic [chess_ctrl_pkg::pos_idx_w-1:0] move_index,
   output chess_ctrl_pkg::position_t            position
);

   import axi_lite_pkg::*;

   axi_wr_req_t            wr_req;
   logic [word_addr_w-1:0] rd_addr;
   logic [data_w-1:0]      sel_data;

   ctrl_axi_write u_write
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .bready  (bready),
      .awready (awready),
      .wready  (wready),
      .bvalid  (bvalid),
      .bresp   (bresp),
      .wr_req  (wr_req)
   );

   position_regs u_regs
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr_req     (wr_req),
      .ctrl       (ctrl),
      .move_index (move_index),
      .position   (position)
   );

   ctrl_read_mux u_mux
   (
      .rd_addr     (rd_addr),
      .ctrl        (ctrl),
      .move_index  (move_index),
      .position    (position),
      .gen_status  (gen_status),
      .move_result (move_result),
      .rdata       (sel_data)
   );

   ctrl_axi_read u_read
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .araddr   (araddr),
      .arvalid  (arvalid),
      .rready   (rready),
      .sel_data (sel_data),
      .arready  (arready),
      .rd_addr  (rd_addr),
      .rvalid   (rvalid),
      .rdata    (rdata),
      .rresp    (rresp)
   );

endmodule

/* logic/ctrl_axi_read.sv */
`timescale 1ns/1ps

module ctrl_axi_read
(
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic [axi_lite_pkg::addr_w-1:0]      araddr,
   input  logic                                 arvalid,
   input  logic                                 rready,
   input  logic [axi_lite_pkg::data_w-1:0]      sel_data,
   output logic                                 arready,
   output logic [axi_lite_pkg::word_addr_w-1:0] rd_addr,
   output logic                                 rvalid,
   output logic [axi_lite_pkg::data_w-1:0]      rdata,
   output axi_lite_pkg::axi_resp_e              rresp
);

   import axi_lite_pkg::*;

   logic accept;

   assign arready = !rvalid;                     // One read in flight
   assign accept  = arvalid && arready;
   assign rd_addr = araddr[word_addr_w+byte_off_w-1:byte_off_w];
   assign rresp   = OKAY;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rvalid <= 1'b0;
      else if (accept)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         rdata <= sel_data;                      // Held until R accepted
   end

endmodule

/* logic/ctrl_read_mux.sv */
`timescale 1ns/1ps

module ctrl_read_mux
(
   input  logic [axi_lite_pkg::word_addr_w-1:0] rd_addr,
   input  chess_ctrl_pkg::ctrl_t                ctrl,
   input  logic [chess_ctrl_pkg::pos_idx_w-1:0] move_index,
   input  chess_ctrl_pkg::position_t            position,
   input  chess_ctrl_pkg::gen_status_t          gen_status,
   input  chess_ctrl_pkg::move_result_t         move_result,
   output logic [axi_lite_pkg::data_w-1:0]      rdata
);

   import axi_lite_pkg::*;
   import chess_ctrl_pkg::*;

   reg_addr_e             addr;
   logic [rank_idx_w-1:0] pos_rank;
   logic [rank_idx_w-1:0] move_rank;
   logic [data_w-1:0]     eval_word;
   logic [data_w-1:0]     uci_word;

   function automatic logic [rank_w-1:0] rank_of
   (
      input logic [board_w-1:0]    board,
      input logic [rank_idx_w-1:0] idx
   );
      return board[idx*rank_w +: rank_w];
   endfunction

   assign addr      = reg_addr_e'(rd_addr);
   assign pos_rank  = rank_idx_w'(addr - BOARD0);
   assign move_rank = rank_idx_w'(addr - MOVE_BOARD0);
   assign eval_word = {{(data_w-eval_w){move_result.eval[eval_w-1]}}, move_result.eval};

   // Row and column fields each padded with a zero bit above
   assign uci_word = data_w'({move_result.uci[15:12], 1'b0, move_result.uci[11:9],
                              1'b0, move_result.uci[8:6], 1'b0, move_result.uci[5:3],
                              1'b0, move_result.uci[2:0]});

   always_comb
   begin
      rdata = '0;
      if (addr inside {[BOARD0:BOARD7]})
         rdata = data_w'(rank_of(position.board, pos_rank));
      else if (addr inside {[MOVE_BOARD0:MOVE_BOARD7]})
         rdata = data_w'(rank_of(move_result.board, move_rank));
      else
         case (addr)
            CTRL:
            begin
               rdata[0]  = ctrl.new_board_valid;
               rdata[1]  = ctrl.clear_moves;
               rdata[2]  = gen_status.moves_ready;
               rdata[3]  = gen_status.move_ready;
               rdata[4]  = gen_status.stalemate;
               rdata[5]  = gen_status.mate;
               rdata[7]  = gen_status.idle;
               rdata[10] = gen_status.check;
               rdata[30] = ctrl.use_random_bit;
               rdata[31] = ctrl.soft_reset;
            end
            MOVE_INDEX: rdata = data_w'(move_index);
            SIDE:
               rdata = data_w'({position.white_to_move, position.castle_mask,
                                position.en_passant_col});
            HALF_MOVE:  rdata = data_w'(position.half_move);
            MOVE_EVAL:  rdata = eval_word;
            MOVE_COUNT: rdata = data_w'(move_result.move_count);
            MOVE_UCI:   rdata = uci_word;
            default:    rdata = '0;        // Unmapped
         endcase
   end

endmodule

/* logic/position_regs.sv */
`timescale 1ns/1ps

module position_regs
(
   input  logic                                clk,
   input  logic                                arst_n,
   input  axi_lite_pkg::axi_wr_req_t           wr_req,
   output chess_ctrl_pkg::ctrl_t               ctrl,
   output logic [chess_ctrl_pkg::pos_idx_w-1:0] move_index,
   output chess_ctrl_pkg::position_t           position
);

   import chess_ctrl_pkg::*;

   reg_addr_e             wr_addr;
   logic                  board_hit;
   logic [rank_idx_w-1:0] board_off;

   assign wr_addr   = reg_addr_e'(wr_req.addr);
   assign board_hit = wr_addr inside {[BOARD0:BOARD7]};
   assign board_off = rank_idx_w'(wr_addr - BOARD0);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ctrl       <= '0;
         move_index <= '0;
         position   <= '0;
      end
      else if (wr_req.strobe)
      begin
         case (wr_addr)
            CTRL:
            begin
               ctrl.new_board_valid <= wr_req.data[0];
               ctrl.clear_moves     <= wr_req.data[1];
               ctrl.use_random_bit  <= wr_req.data[30];
               ctrl.soft_reset      <= wr_req.data[31];
            end
            MOVE_INDEX:
               move_index <= wr_req.data[pos_idx_w-1:0];
            SIDE:
               {position.white_to_move, position.castle_mask, position.en_passant_col}
                  <= wr_req.data[8:0];
            HALF_MOVE:
               position.half_move <= wr_req.data[half_move_w-1:0];
            default:
               if (board_hit)
                  position.board[board_off*rank_w +: rank_w] <= wr_req.data[rank_w-1:0];
         endcase
      end
   end

endmodule

/* logic/ctrl_axi_write.sv */
`timescale 1ns/1ps

module ctrl_axi_write
(
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic [axi_lite_pkg::addr_w-1:0] awaddr,
   input  logic                            awvalid,
   input  logic [axi_lite_pkg::data_w-1:0] wdata,
   input  logic                            wvalid,
   input  logic                            bready,
   output logic                            awready,
   output logic                            wready,
   output logic                            bvalid,
   output axi_lite_pkg::axi_resp_e         bresp,
   output axi_lite_pkg::axi_wr_req_t       wr_req
);

   import axi_lite_pkg::*;

   typedef enum logic {
      IDLE,
      RESP
   } state_e;

   state_e                 state_q;
   state_e                 state_d;
   logic                   ready_q;
   logic                   accept;
   logic                   strobe_q;
   logic [word_addr_w-1:0] addr_q;
   logic [data_w-1:0]      data_q;

   assign accept = ready_q && awvalid && wvalid;   // Address and data together

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
            if (accept)
               state_d = RESP;
         RESP:
            if (bready)
               state_d = IDLE;
         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state_q  <= IDLE;
         ready_q  <= 1'b0;                       // Low while in reset
         strobe_q <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         ready_q  <= (state_d == IDLE);
         strobe_q <= accept;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         addr_q <= awaddr[word_addr_w+byte_off_w-1:byte_off_w];
         data_q <= wdata;
      end
   end

   assign awready = ready_q;
   assign wready  = ready_q;
   assign bvalid  = (state_q == RESP);
   assign bresp   = OKAY;
   assign wr_req  = '{strobe: strobe_q, addr: addr_q, data: data_q};

endmodule

/* logic/chess_ctrl_pkg.sv */
package chess_ctrl_pkg;

   localparam int rank_w      = 32;             // 8 squares of 4 bits
   localparam int ranks       = 8;
   localparam int board_w     = rank_w * ranks;
   localparam int rank_idx_w  = $clog2(ranks);
   localparam int pos_idx_w   = 8;
   localparam int half_move_w = 8;
   localparam int eval_w      = 24;
   localparam int uci_w       = 16;             // Promotion, from, to

   typedef enum logic [axi_lite_pkg::word_addr_w-1:0] {
      CTRL        = 14'd0,
      MOVE_INDEX  = 14'd1,
      SIDE        = 14'd2,
      HALF_MOVE   = 14'd3,
      BOARD0      = 14'd8,
      BOARD1      = 14'd9,
      BOARD2      = 14'd10,
      BOARD3      = 14'd11,
      BOARD4      = 14'd12,
      BOARD5      = 14'd13,
      BOARD6      = 14'd14,
      BOARD7      = 14'd15,
      MOVE_EVAL   = 14'd134,
      MOVE_COUNT  = 14'd135,
      MOVE_UCI    = 14'd139,
      MOVE_BOARD0 = 14'd172,
      MOVE_BOARD1 = 14'd173,
      MOVE_BOARD2 = 14'd174,
      MOVE_BOARD3 = 14'd175,
      MOVE_BOARD4 = 14'd176,
      MOVE_BOARD5 = 14'd177,
      MOVE_BOARD6 = 14'd178,
      MOVE_BOARD7 = 14'd179
   } reg_addr_e;

   typedef struct packed {
      logic new_board_valid;
      logic clear_moves;
      logic use_random_bit;
      logic soft_reset;
   } ctrl_t;

   typedef struct packed {
      logic                   white_to_move;
      logic [3:0]             castle_mask;
      logic [3:0]             en_passant_col;
      logic [half_move_w-1:0] half_move;
      logic [board_w-1:0]     board;     // Rank 0 in the low bits
   } position_t;

   typedef struct packed {
      logic idle;
      logic moves_ready;                 // All moves generated
      logic move_ready;                  // Indexed move valid
      logic mate;
      logic stalemate;
      logic check;
   } gen_status_t;

   typedef struct packed {
      logic signed [eval_w-1:0] eval;
      logic [pos_idx_w-1:0]     move_count;
      logic [uci_w-1:0]         uci;
      logic [board_w-1:0]       board;
   } move_result_t;

endpackage

/* logic/axi_lite_pkg.sv */
package axi_lite_pkg;

   localparam int addr_w      = 40;
   localparam int data_w      = 32;
   localparam int strb_w      = data_w / 8;
   localparam int prot_w      = 3;
   localparam int byte_off_w  = $clog2(strb_w);
   localparam int word_addr_w = 14;             // Register word address

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // One accepted AW/W pair, valid for a single cycle
   typedef struct packed {
      logic                   strobe;
      logic [word_addr_w-1:0] addr;
      logic [data_w-1:0]      data;
   } axi_wr_req_t;

endpackage
